//--- hw/ex_pkg.sv
// Shared widths, opcode encodings and the product type of the execute stage
// Imported by every RTL block that decodes operations or handles the product

package ex_pkg;

  localparam int unsigned xlen       = 32;  // Data word width
  localparam int unsigned reg_addr_w = 6;   // Register file address width

  //////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////

  // ALU operations, numeric order is fixed by the ID stage encoding
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_eq   = 4'd10,  // Branch comparisons from here on
    alu_ne   = 4'd11,
    alu_lt   = 4'd12,
    alu_ge   = 4'd13,
    alu_ltu  = 4'd14,
    alu_geu  = 4'd15
  } alu_op_e;

  // RV32M multiply variants
  typedef enum logic [1:0] {
    mul_mul    = 2'd0,  // Low word
    mul_mulh   = 2'd1,  // High word, signed x signed
    mul_mulhsu = 2'd2,  // High word, signed x unsigned
    mul_mulhu  = 2'd3   // High word, unsigned x unsigned
  } mul_op_e;

  //////////////////////////////////////////////////
  // Product word
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [xlen-1:0] hi;
    logic [xlen-1:0] lo;
  } product_words_t;

  // Same 64 bits seen whole for arithmetic or split for word select
  typedef union packed {
    logic [2*xlen-1:0] full;
    product_words_t    words;
  } product_u;

endpackage

//--- hw/ex_alu.sv
// Single-cycle integer ALU with the branch comparator
// Purely combinational, the result is valid in the cycle the operands arrive

module ex_alu (
  input  ex_pkg::alu_op_e          operator_i,
  input  logic [ex_pkg::xlen-1:0]  operand_a_i,
  input  logic [ex_pkg::xlen-1:0]  operand_b_i,
  output logic [ex_pkg::xlen-1:0]  result_o,
  output logic                     cmp_result_o
);

  import ex_pkg::*;

  logic [xlen-1:0] add_res;  // Adder output, shared by add and sub
  logic [4:0]      shamt;    // Shift amount
  logic            is_eq;
  logic            lt_signed;
  logic            lt_unsigned;

  assign add_res = (operator_i == alu_sub) ? operand_a_i - operand_b_i
                                           : operand_a_i + operand_b_i;
  assign shamt   = operand_b_i[4:0];  // RV32 uses the low five bits only

  //////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////

  assign is_eq       = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  // One decision for SLT/SLTU and for the branch flavours
  always_comb begin
    case (operator_i)
      alu_eq:           cmp_result_o = is_eq;
      alu_ne:           cmp_result_o = ~is_eq;
      alu_slt, alu_lt:  cmp_result_o = lt_signed;
      alu_ge:           cmp_result_o = ~lt_signed;
      alu_sltu,
      alu_ltu:          cmp_result_o = lt_unsigned;
      alu_geu:          cmp_result_o = ~lt_unsigned;
      default:          cmp_result_o = 1'b0;  // Not a compare
    endcase
  end

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      alu_add,
      alu_sub: result_o = add_res;
      alu_and: result_o = operand_a_i & operand_b_i;
      alu_or:  result_o = operand_a_i | operand_b_i;
      alu_xor: result_o = operand_a_i ^ operand_b_i;
      alu_sll: result_o = operand_a_i << shamt;
      alu_srl: result_o = operand_a_i >> shamt;
      alu_sra: result_o = $unsigned($signed(operand_a_i) >>> shamt);  // Sign fill
      // Compares return 0 or 1 in bit zero
      default: result_o = {{(xlen-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

//--- hw/ex_mult_ctrl.sv
// Sequencer for the iterative multiplier
// Loads the operands, runs the steps, then holds the result until EX releases it

module ex_mult_ctrl #(
  parameter int unsigned mul_step_bits = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic mult_en_i,     // Multiply presented by ID
  input  logic ex_ready_i,    // Stage accepts, result may be dropped
  input  logic step_last_i,   // Final iteration from the step counter
  output logic step_start_o,  // Load operands and counter
  output logic step_en_o,     // Retire one group of multiplier bits
  output logic mult_ready_o,
  output logic multicycle_o
);

  import ex_pkg::*;

  localparam int unsigned mul_steps = xlen / mul_step_bits;

  // The step size has to split the word evenly and leave at least two steps
  if ((mul_steps * mul_step_bits != xlen) || (mul_steps < 2)) begin : gen_bad_step
    $error("mul_step_bits must divide xlen into two or more steps");
  end

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_busy = 2'd1;
  localparam logic [1:0] st_done = 2'd2;  // Result held for WB

  logic [1:0] state_q;
  logic [1:0] state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (mult_en_i)   state_d = st_busy;
      st_busy: if (step_last_i) state_d = st_done;
      st_done: if (ex_ready_i)  state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign step_start_o = (state_q == st_idle) & mult_en_i;  // Acceptance cycle
  assign step_en_o    = (state_q == st_busy);
  assign multicycle_o = (state_q == st_busy);
  // Not ready while a multiply waits to load or is still iterating
  assign mult_ready_o = (state_q == st_done) | ((state_q == st_idle) & ~mult_en_i);

endmodule

//--- hw/ex_mult_cnt.sv
// Iteration counter for the multiplier
// Loaded on start, flags the last step so the sequencer stays step-count agnostic

module ex_mult_cnt #(
  parameter int unsigned mul_step_bits = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,  // Reload for a new multiply
  input  logic en_i,     // One step retired this cycle
  output logic last_o
);

  import ex_pkg::*;

  localparam int unsigned mul_steps = xlen / mul_step_bits;
  localparam int unsigned cnt_w     = $clog2(mul_steps);

  logic [cnt_w-1:0] cnt_q;  // Steps still to go after the current one

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= cnt_w'(mul_steps - 1);
    end else if (en_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;  // Stops at zero
    end
  end

  assign last_o = (cnt_q == '0);

endmodule

//--- hw/ex_mult_dp.sv
// Shift-add multiply datapath for MUL, MULH, MULHSU and MULHU
// Works on magnitudes and fixes the sign at the output, several bits per step

module ex_mult_dp #(
  parameter int unsigned mul_step_bits = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start_i,    // Latch operands, clear accumulator
  input  logic                    step_en_i,  // Add one group of partial products
  input  ex_pkg::mul_op_e         operator_i,
  input  logic [ex_pkg::xlen-1:0] op_a_i,
  input  logic [ex_pkg::xlen-1:0] op_b_i,
  output logic [ex_pkg::xlen-1:0] result_o
);

  import ex_pkg::*;

  logic              a_signed;
  logic              b_signed;
  logic              a_neg;
  logic              b_neg;
  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;

  logic [2*xlen-1:0] mcand_q;   // Multiplicand, moves left each step
  logic [xlen-1:0]   mplier_q;  // Multiplier, moves right each step
  product_u          acc_q;     // Running product magnitude
  logic              neg_q;     // Product sign
  logic              hi_q;      // Return the high word
  logic [2*xlen-1:0] step_sum;
  product_u          prod;

  //////////////////////////////////////////////////
  // Operand signs and magnitudes
  //////////////////////////////////////////////////

  assign a_signed = (operator_i == mul_mulh) || (operator_i == mul_mulhsu);
  assign b_signed = (operator_i == mul_mulh);
  assign a_neg    = a_signed & op_a_i[xlen-1];
  assign b_neg    = b_signed & op_b_i[xlen-1];
  assign a_mag    = a_neg ? -op_a_i : op_a_i;  // 0x80000000 maps onto itself
  assign b_mag    = b_neg ? -op_b_i : op_b_i;

  // Partial products of the low mul_step_bits multiplier bits
  always_comb begin
    step_sum = '0;
    for (int i = 0; i < mul_step_bits; i++) begin
      if (mplier_q[i]) step_sum = step_sum + (mcand_q << i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      neg_q <= 1'b0;
      hi_q  <= 1'b0;
    end else if (start_i) begin
      neg_q <= a_neg ^ b_neg;
      hi_q  <= (operator_i != mul_mul);
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      mcand_q    <= {{xlen{1'b0}}, a_mag};
      mplier_q   <= b_mag;
      acc_q.full <= '0;
    end else if (step_en_i) begin
      acc_q.full <= acc_q.full + step_sum;
      mcand_q    <= mcand_q << mul_step_bits;
      mplier_q   <= mplier_q >> mul_step_bits;
    end
  end

  //////////////////////////////////////////////////
  // Sign fix and word select
  //////////////////////////////////////////////////

  always_comb begin
    prod.full = neg_q ? -acc_q.full : acc_q.full;
    result_o  = hi_q ? prod.words.hi : prod.words.lo;  // Held until next start
  end

endmodule

//--- hw/ex_writeback.sv
// Write-back side of the execute stage
// ALU-port forwarding mux, EX/WB register for the LSU port and stage ready/valid

module ex_writeback (
  input  logic                          clk,
  input  logic                          rst_n,

  // Operation enables from ID
  input  logic                          alu_en_i,
  input  logic                          mult_en_i,
  input  logic                          csr_access_i,
  input  logic                          lsu_en_i,

  // Result sources
  input  logic [ex_pkg::xlen-1:0]       alu_result_i,
  input  logic [ex_pkg::xlen-1:0]       mult_result_i,
  input  logic [ex_pkg::xlen-1:0]       csr_rdata_i,

  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] regfile_alu_waddr_i,
  input  logic                          regfile_we_i,     // Passed on to WB
  input  logic [ex_pkg::reg_addr_w-1:0] regfile_waddr_i,

  input  logic [ex_pkg::xlen-1:0]       lsu_rdata_i,
  input  logic                          lsu_err_i,
  input  logic                          lsu_ready_ex_i,   // LSU done with EX part
  input  logic                          wb_ready_i,
  input  logic                          branch_in_ex_i,
  input  logic                          mult_ready_i,

  // Forwarding port towards ID and the register file
  output logic                          regfile_alu_we_fw_o,
  output logic [ex_pkg::reg_addr_w-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_pkg::xlen-1:0]       regfile_alu_wdata_fw_o,

  // LSU write port
  output logic                          regfile_we_wb_o,
  output logic [ex_pkg::reg_addr_w-1:0] regfile_waddr_wb_o,
  output logic [ex_pkg::xlen-1:0]       regfile_wdata_wb_o,

  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);

  import ex_pkg::*;

  logic                  we_lsu_q;
  logic [reg_addr_w-1:0] waddr_lsu_q;

  //////////////////////////////////////////////////
  // ALU write port
  //////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over multiply, multiply over ALU
  assign regfile_alu_wdata_fw_o = csr_access_i ? csr_rdata_i   :
                                  mult_en_i    ? mult_result_i :
                                  alu_en_i     ? alu_result_i  : '0;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q <= 1'b0;
    end else if (ex_valid_o) begin  // WB ready is implied
      we_lsu_q <= regfile_we_i & ~lsu_err_i;  // Faulting load writes nothing
    end else if (wb_ready_i) begin
      we_lsu_q <= 1'b0;  // Bubble, flush the slot
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o) waddr_lsu_q <= regfile_waddr_i;
  end

  assign regfile_we_wb_o    = we_lsu_q;
  assign regfile_waddr_wb_o = waddr_lsu_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;  // Load data arrives in WB

  // Branches finish in EX, so they never wait for WB
  assign ex_ready_o = (mult_ready_i & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & mult_ready_i & lsu_ready_ex_i & wb_ready_i;

endmodule

//--- hw/ex_stage.sv
// Top of the integer execute stage
// Hooks the ALU, the multicycle multiplier and the write-back logic together

module ex_stage #(
  parameter int unsigned mul_step_bits = 4  // Multiplier bits retired per cycle
) (
  input  logic                          clk,
  input  logic                          rst_n,

  // ALU operands from ID
  input  ex_pkg::alu_op_e               alu_operator_i,
  input  logic [ex_pkg::xlen-1:0]       alu_operand_a_i,
  input  logic [ex_pkg::xlen-1:0]       alu_operand_b_i,
  input  logic [ex_pkg::xlen-1:0]       alu_operand_c_i,  // Jump target
  input  logic                          alu_en_i,

  // Multiplier operands from ID
  input  ex_pkg::mul_op_e               mult_operator_i,
  input  logic [ex_pkg::xlen-1:0]       mult_operand_a_i,
  input  logic [ex_pkg::xlen-1:0]       mult_operand_b_i,
  input  logic                          mult_en_i,
  output logic                          mult_multicycle_o,

  input  logic                          csr_access_i,
  input  logic [ex_pkg::xlen-1:0]       csr_rdata_i,

  input  logic                          lsu_en_i,
  input  logic [ex_pkg::xlen-1:0]       lsu_rdata_i,
  input  logic                          lsu_err_i,
  input  logic                          lsu_ready_ex_i,

  input  logic                          branch_in_ex_i,
  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] regfile_alu_waddr_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] regfile_waddr_i,

  output logic                          regfile_we_wb_o,
  output logic [ex_pkg::reg_addr_w-1:0] regfile_waddr_wb_o,
  output logic [ex_pkg::xlen-1:0]       regfile_wdata_wb_o,
  output logic                          regfile_alu_we_fw_o,
  output logic [ex_pkg::reg_addr_w-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_pkg::xlen-1:0]       regfile_alu_wdata_fw_o,

  // To IF
  output logic [ex_pkg::xlen-1:0]       jump_target_o,
  output logic                          branch_decision_o,

  output logic                          ex_ready_o,
  output logic                          ex_valid_o,
  input  logic                          wb_ready_i
);

  import ex_pkg::*;

  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] mult_result;
  logic            mult_ready;
  logic            step_start;  // Multiply accepted
  logic            step_en;
  logic            step_last;

  assign jump_target_o = alu_operand_c_i;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  ex_alu alu_i (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  //////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////

  ex_mult_ctrl #(.mul_step_bits(mul_step_bits)) mult_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_en_i    (mult_en_i),
    .ex_ready_i   (ex_ready_o),
    .step_last_i  (step_last),
    .step_start_o (step_start),
    .step_en_o    (step_en),
    .mult_ready_o (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_mult_cnt #(.mul_step_bits(mul_step_bits)) mult_cnt_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (step_start),
    .en_i    (step_en),
    .last_o  (step_last)
  );

  ex_mult_dp #(.mul_step_bits(mul_step_bits)) mult_dp_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (step_start),
    .step_en_i  (step_en),
    .operator_i (mult_operator_i),
    .op_a_i     (mult_operand_a_i),
    .op_b_i     (mult_operand_b_i),
    .result_o   (mult_result)
  );

  //////////////////////////////////////////////////
  // Write-back and handshake
  //////////////////////////////////////////////////

  ex_writeback wb_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_err_i              (lsu_err_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .mult_ready_i           (mult_ready),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

//--- verif/ex_stage_chk.sv
// Protocol assertions for the execute stage
// Bound into ex_stage from the testbench, reports only through assertion failures

module ex_stage_chk (
  input logic clk,
  input logic rst_n,
  input logic ex_valid_i,    // Stage output valid
  input logic wb_ready_i,
  input logic multicycle_i,  // Multiplier iterating
  input logic we_wb_i        // LSU port write enable
);

  //////////////////////////////////////////////////
  // Handshake rules
  //////////////////////////////////////////////////

  // Nothing leaves EX unless WB can take it
  valid_needs_wb : assert property (
    @(posedge clk) disable iff (!rst_n) ex_valid_i |-> wb_ready_i
  ) else $error("ex_valid_o high while wb_ready_i is low");

  // A multiply still iterating cannot complete
  busy_not_valid : assert property (
    @(posedge clk) disable iff (!rst_n) multicycle_i |-> !ex_valid_i
  ) else $error("ex_valid_o high while mult_multicycle_o is high");

  //////////////////////////////////////////////////
  // Reset state
  //////////////////////////////////////////////////

  reset_we_low : assert property (
    @(posedge clk) $rose(rst_n) |-> !we_wb_i
  ) else $error("regfile_we_wb_o high in the first cycle after reset");

endmodule

//--- verif/ex_stage_tb.sv
// Directed testbench for the execute stage
// Reads vectors from verif/ex_stimulus.txt, drives the DUT and checks every response

module ex_stage_tb;

  import ex_pkg::*;

  localparam int unsigned mul_step_bits = 4;
  localparam int unsigned mul_steps     = xlen / mul_step_bits;
  localparam int          wait_limit    = 4 * mul_steps;  // Cycles before a wait gives up

  logic clk;
  logic rst_n;
  alu_op_e alu_operator;
  logic [31:0] alu_a, alu_b, alu_c;
  logic alu_en;
  mul_op_e mult_operator;
  logic [31:0] mult_a, mult_b;
  logic mult_en, mult_multicycle_o;
  logic csr_access;
  logic [31:0] csr_rdata;
  logic lsu_en, lsu_err, lsu_ready_ex;
  logic [31:0] lsu_rdata;
  logic branch_in_ex, regfile_alu_we, regfile_we, wb_ready;
  logic [5:0] regfile_alu_waddr, regfile_waddr;
  logic regfile_we_wb_o, regfile_alu_we_fw_o, branch_decision_o;
  logic [5:0] regfile_waddr_wb_o, regfile_alu_waddr_fw_o;
  logic [31:0] regfile_wdata_wb_o, regfile_alu_wdata_fw_o, jump_target_o;
  logic ex_ready_o, ex_valid_o;

  string cur_name, cur_kind;  // Current vector fields
  int cur_op, cur_waddr, cur_cmp;
  logic [31:0] cur_a, cur_b, cur_c, cur_exp;
  bit test_ok;
  int n_pass, n_fail;

  ex_stage #(.mul_step_bits(mul_step_bits)) dut_i (
    .clk(clk), .rst_n(rst_n),
    .alu_operator_i(alu_operator), .alu_operand_a_i(alu_a), .alu_operand_b_i(alu_b),
    .alu_operand_c_i(alu_c), .alu_en_i(alu_en),
    .mult_operator_i(mult_operator), .mult_operand_a_i(mult_a), .mult_operand_b_i(mult_b),
    .mult_en_i(mult_en), .mult_multicycle_o(mult_multicycle_o),
    .csr_access_i(csr_access), .csr_rdata_i(csr_rdata),
    .lsu_en_i(lsu_en), .lsu_rdata_i(lsu_rdata), .lsu_err_i(lsu_err),
    .lsu_ready_ex_i(lsu_ready_ex), .branch_in_ex_i(branch_in_ex),
    .regfile_alu_we_i(regfile_alu_we), .regfile_alu_waddr_i(regfile_alu_waddr),
    .regfile_we_i(regfile_we), .regfile_waddr_i(regfile_waddr),
    .regfile_we_wb_o(regfile_we_wb_o), .regfile_waddr_wb_o(regfile_waddr_wb_o),
    .regfile_wdata_wb_o(regfile_wdata_wb_o), .regfile_alu_we_fw_o(regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o(regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o(regfile_alu_wdata_fw_o),
    .jump_target_o(jump_target_o), .branch_decision_o(branch_decision_o),
    .ex_ready_o(ex_ready_o), .ex_valid_o(ex_valid_o), .wb_ready_i(wb_ready)
  );

  bind ex_stage ex_stage_chk chk_i (
    .clk(clk), .rst_n(rst_n), .ex_valid_i(ex_valid_o), .wb_ready_i(wb_ready_i),
    .multicycle_i(mult_multicycle_o), .we_wb_i(regfile_we_wb_o)
  );

  always #4 clk = ~clk;  // Period 8

  //////////////////////////////////////////////////
  // Drive and check helpers
  //////////////////////////////////////////////////

  task automatic clear_inputs;  // Idle ID side with WB and LSU ready
    alu_operator = alu_add;
    alu_a = '0;
    alu_b = '0;
    alu_c = '0;
    alu_en = 1'b0;
    mult_operator = mul_mul;
    mult_a = '0;
    mult_b = '0;
    mult_en = 1'b0;
    csr_access = 1'b0;
    csr_rdata = '0;
    lsu_en = 1'b0;
    lsu_err = 1'b0;
    lsu_rdata = '0;
    lsu_ready_ex = 1'b1;
    branch_in_ex = 1'b0;
    wb_ready = 1'b1;
    regfile_alu_we = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we = 1'b0;
    regfile_waddr = '0;
  endtask

  task automatic after_edge;
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
      test_ok = 0;
    end
  endtask

  // Samples at the falling edge until ex_valid_o or until wait_limit cycles have passed
  task automatic wait_valid(output int cycles);
    cycles = 0;
    @(negedge clk);
    while (!ex_valid_o && cycles < wait_limit) begin
      cycles++;
      @(negedge clk);
    end
    if (!ex_valid_o) begin
      $display("Timeout: %s saw no ex_valid_o within %0d cycles", cur_name, wait_limit);
      test_ok = 0;
    end
  endtask

  //////////////////////////////////////////////////
  // One task per vector kind
  //////////////////////////////////////////////////

  task automatic drive_alu_csr(input bit csr);  // CSR data must win over the ALU result
    int cycles;
    after_edge;
    alu_operator = alu_op_e'(cur_op[3:0]);
    alu_a = cur_a;
    alu_b = cur_b;
    alu_en = 1'b1;
    csr_access = csr;
    csr_rdata = cur_c;
    regfile_alu_we = 1'b1;
    regfile_alu_waddr = cur_waddr[5:0];
    wait_valid(cycles);
    check_word("latency", 32'd0, 32'(cycles));
    check_word("wdata", cur_exp, regfile_alu_wdata_fw_o);
    check_word("alu_we", 32'd1, 32'(regfile_alu_we_fw_o));
    check_word("alu_waddr", 32'(cur_waddr[5:0]), 32'(regfile_alu_waddr_fw_o));
    if (!csr) check_word("cmp", 32'(cur_cmp), 32'(branch_decision_o));
    after_edge;
    clear_inputs;
  endtask

  task automatic resolve_branch;  // Branch resolves with WB stalled
    after_edge;
    alu_operator = alu_op_e'(cur_op[3:0]);
    alu_a = cur_a;
    alu_b = cur_b;
    alu_c = cur_c;
    alu_en = 1'b1;
    branch_in_ex = 1'b1;
    wb_ready = 1'b0;
    @(negedge clk);
    check_word("decision", 32'(cur_cmp), 32'(branch_decision_o));
    check_word("target", cur_exp, jump_target_o);
    check_word("ex_ready", 32'd1, 32'(ex_ready_o));
    after_edge;
    clear_inputs;
  endtask

  task automatic run_multiply;
    int cycles;
    after_edge;
    mult_operator = mul_op_e'(cur_op[1:0]);
    mult_a = cur_a;
    mult_b = cur_b;
    mult_en = 1'b1;
    regfile_alu_we = 1'b1;
    regfile_alu_waddr = cur_waddr[5:0];
    cycles = 0;
    @(negedge clk);  // Acceptance cycle
    while (!ex_valid_o && cycles < wait_limit) begin
      if (cycles > 0 && (!mult_multicycle_o || ex_ready_o)) begin
        $display("%s: busy flags wrong in cycle %0d of the multiply", cur_name, cycles);
        test_ok = 0;
      end
      cycles++;
      @(negedge clk);
    end
    if (!ex_valid_o) begin
      $display("Timeout: %s multiply never completed", cur_name);
      test_ok = 0;
    end else begin
      check_word("latency", mul_steps + 1, 32'(cycles));
      check_word("product", cur_exp, regfile_alu_wdata_fw_o);
    end
    after_edge;
    clear_inputs;
  endtask

  task automatic stall_multiply;  // cur_c extra cycles with WB held off after completion
    int cycles;
    bit seen_busy;
    after_edge;
    mult_operator = mul_op_e'(cur_op[1:0]);
    mult_a = cur_a;
    mult_b = cur_b;
    mult_en = 1'b1;
    wb_ready = 1'b0;
    cycles = 0;
    seen_busy = 0;
    @(negedge clk);
    while (!(seen_busy && !mult_multicycle_o) && cycles < wait_limit) begin
      if (mult_multicycle_o) seen_busy = 1;
      cycles++;
      @(negedge clk);
    end
    if (mult_multicycle_o || !seen_busy) begin
      $display("Timeout: %s multiply did not reach its done state", cur_name);
      test_ok = 0;
    end
    repeat (cur_c) begin
      if (ex_valid_o) begin
        $display("%s: ex_valid_o rose while wb_ready_i was low", cur_name);
        test_ok = 0;
      end
      check_word("held product", cur_exp, regfile_alu_wdata_fw_o);
      @(negedge clk);
    end
    after_edge;
    wb_ready = 1'b1;
    wait_valid(cycles);
    check_word("release latency", 32'd0, 32'(cycles));
    check_word("product", cur_exp, regfile_alu_wdata_fw_o);
    after_edge;
    clear_inputs;
  endtask

  task automatic load_through_wb;  // cur_op is the LSU error flag
    int cycles;
    after_edge;
    lsu_en = 1'b1;
    lsu_err = cur_op[0];
    regfile_we = 1'b1;
    regfile_waddr = cur_waddr[5:0];
    wait_valid(cycles);
    after_edge;
    lsu_en = 1'b0;
    regfile_we = 1'b0;
    lsu_err = 1'b0;
    lsu_rdata = cur_a;  // Load data arrives in the WB cycle
    @(negedge clk);
    check_word("we_wb", 32'(cur_cmp), 32'(regfile_we_wb_o));
    if (cur_cmp != 0) begin
      check_word("waddr_wb", 32'(cur_waddr[5:0]), 32'(regfile_waddr_wb_o));
      check_word("wdata_wb", cur_exp, regfile_wdata_wb_o);
    end
    @(negedge clk);  // Idle cycle with WB ready flushes the slot
    check_word("flushed we_wb", 32'd0, 32'(regfile_we_wb_o));
    after_edge;
    clear_inputs;
  endtask

  //////////////////////////////////////////////////
  // Vector loop
  //////////////////////////////////////////////////

  initial begin
    int fd;
    int nf;
    string line;
    clk = 1'b0;
    rst_n = 1'b0;
    n_pass = 0;
    n_fail = 0;
    clear_inputs;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    fd = $fopen("verif/ex_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file verif/ex_stimulus.txt");
      n_fail++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        if (line.len() < 2 || line[0] == "#") continue;  // Blank or column notes
        nf = $sscanf(line, "%s %s %d %h %h %h %d %h %d", cur_name, cur_kind, cur_op,
                     cur_a, cur_b, cur_c, cur_waddr, cur_exp, cur_cmp);
        if (nf != 9) begin
          $display("Malformed stimulus line: %s", line);
          n_fail++;
          continue;
        end
        test_ok = 1;
        if (cur_kind == "alu") drive_alu_csr(1'b0);
        else if (cur_kind == "csr") drive_alu_csr(1'b1);
        else if (cur_kind == "branch") resolve_branch;
        else if (cur_kind == "mult") run_multiply;
        else if (cur_kind == "stall") stall_multiply;
        else if (cur_kind == "lsu") load_through_wb;
        else begin
          $display("%s: unknown test kind %s", cur_name, cur_kind);
          test_ok = 0;
        end
        if (test_ok) n_pass++;
        else n_fail++;
        $display("test %-12s %-6s %s", cur_name, cur_kind, test_ok ? "ok" : "FAIL");
      end
      $fclose(fd);
    end
    if (n_pass + n_fail == 0) begin
      $display("No test vectors were run");
      n_fail++;
    end
    $display("%0d tests, %0d ok, %0d with errors", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- verif/ex_stimulus.txt
# name kind op a b c waddr exp_result exp_cmp (op decimal, a b c and exp_result hex)
# op: alu_op_e or mul_op_e code, lsu error flag; branch exp is target; stall c is hold cycles
add_ovf    alu    0  7fffffff 00000001 00000000 5  80000000 0
sub_neg    alu    1  00000005 00000007 00000000 6  fffffffe 0
and_mask   alu    2  f0f0f0f0 ff00ff00 00000000 7  f000f000 0
or_mix     alu    3  f0f0f0f0 0f0000ff 00000000 8  fff0f0ff 0
xor_mix    alu    4  aaaa5555 ffff0000 00000000 9  55555555 0
sll_shamt  alu    5  00000001 0000003f 00000000 10 80000000 0
srl_msb    alu    6  80000000 00000004 00000000 11 08000000 0
sra_msb    alu    7  80000000 00000004 00000000 12 f8000000 0
slt_neg    alu    8  ffffffff 00000001 00000000 13 00000001 1
sltu_big   alu    9  ffffffff 00000001 00000000 14 00000000 0
eq_same    alu    10 12345678 12345678 00000000 15 00000001 1
ne_same    alu    11 12345678 12345678 00000000 16 00000000 0
lt_min     alu    12 80000000 7fffffff 00000000 17 00000001 1
ge_min     alu    13 80000000 7fffffff 00000000 18 00000000 0
ltu_min    alu    14 80000000 7fffffff 00000000 19 00000000 0
geu_min    alu    15 80000000 7fffffff 00000000 20 00000001 1
br_eq      branch 10 00000010 00000010 00001000 0  00001000 1
br_lt      branch 12 fffffff0 00000003 00002004 0  00002004 1
br_geu     branch 15 00000003 fffffff0 00003008 0  00003008 0
mul_neg    mult   0  fffffffe 00000003 00000000 21 fffffffa 0
mulh_min   mult   1  80000000 80000000 00000000 22 40000000 0
mulh_mix   mult   1  80000000 7fffffff 00000000 23 c0000000 0
mulhsu_m1  mult   2  ffffffff ffffffff 00000000 24 ffffffff 0
mulhu_max  mult   3  ffffffff ffffffff 00000000 25 fffffffe 0
mul_stall  stall  3  00010000 00010000 00000003 26 00000001 0
csr_wins   csr    0  00000001 00000002 cafef00d 27 cafef00d 0
lsu_load   lsu    0  deadbeef 00000000 00000000 28 deadbeef 1
lsu_fault  lsu    1  0badf00d 00000000 00000000 29 0badf00d 0

//--- list.f
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_mult_ctrl.sv
hw/ex_mult_cnt.sv
hw/ex_mult_dp.sv
hw/ex_writeback.sv
hw/ex_stage.sv
verif/ex_stage_chk.sv
verif/ex_stage_tb.sv

//--- run.sh
#!/bin/sh
# Compile the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ex_stage_tb -f list.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vex_stage_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
  exit 0
fi
exit 1
